// ==== common/ucode_pkg.sv ====
// Microcode definitions shared by the control unit stages.
// Holds the control word layout, the store geometry, the opcode
// category codes and the entry points of the indexed sub-routines.
// Import inside a module body; use scoped names in port lists.

package ucode_pkg;

    localparam int UCODE_AW  = 10;   // 1024 store words
    localparam int OPCAT_AW  = 6;    // 64 routines of 16 words
    localparam int UCODE_DW  = 32;
    localparam int ENTRY_PAD = UCODE_AW - OPCAT_AW;

    localparam string UCODE_HEX = "ucode/ucode.hex";

    // one store word, msb first
    typedef struct packed {
        logic [3:0] spare;
        logic       adrx;
        logic       adry;
        logic       adridx;
        logic       decb;
        logic       decx;
        logic       incx;
        logic       mem16;
        logic       we;
        logic       psh_go;
        logic       pul_go;
        logic       pshall;
        logic       pshcc;
        logic       pshpc;
        logic       set_e;
        logic       clr_e;
        logic       set_f;
        logic       set_i;
        logic       set_opn0_mem;
        logic       set_opn0_regs;
        logic       set_pc_branch;
        logic       set_pc_rst;
        logic       set_pc_puls;
        logic       rti_cc;
        // sequencing bits, read back by the sequencer
        logic       ni;             // fetch next instruction
        logic       jmp_idx;        // dispatch on postbyte
        logic       idx_ret;        // back to the after-index routine
        logic       skip_noind;     // skip a word if not indirect
        logic       idx_en;         // index unit active
    } ucode_ctrl_t;

    // routine categories, 0x00 block holds the reset routine
    typedef enum logic [OPCAT_AW-1:0] {
        SINGLE_ALU       = 6'h01,
        SINGLE_ALU16     = 6'h02,
        SINGLE_ALU_INH   = 6'h03,
        PARSE_IDX        = 6'h04,
        SINGLE_ALU_IDX   = 6'h05,
        SINGLE_ALU_IDX16 = 6'h06,
        SBRANCH          = 6'h07,
        LBRANCH          = 6'h08,
        JUMP             = 6'h09,
        PSH              = 6'h0a,
        PUL              = 6'h0b,
        RTIT             = 6'h0c,
        NOPE             = 6'h0d,
        STORE8           = 6'h0e,
        STORE16          = 6'h0f,
        IRQ_ENTRY        = 6'h20,
        FIRQ_ENTRY       = 6'h21,
        NMI_ENTRY        = 6'h22,
        BUSERROR         = 6'h3f
    } opcat_e;

    // indexed sub-routines, one 16-word block each
    localparam logic [UCODE_AW-1:0] IDX_SUM      = 10'h280;
    localparam logic [UCODE_AW-1:0] IDX_RINC     = 10'h290;
    localparam logic [UCODE_AW-1:0] IDX_RINC2    = 10'h2a0;
    localparam logic [UCODE_AW-1:0] IDX_RDEC     = 10'h2b0;
    localparam logic [UCODE_AW-1:0] IDX_RDEC2    = 10'h2c0;
    localparam logic [UCODE_AW-1:0] IDX_OFFSET8  = 10'h2d0;
    localparam logic [UCODE_AW-1:0] IDX_OFFSET16 = 10'h2e0;
    localparam logic [UCODE_AW-1:0] IDX_EXTIND   = 10'h2f0;

    // stage 1 to stage 2
    typedef struct packed {
        opcat_e opcat;
        opcat_e after_idx;      // routine to resume after indexing
        logic   idx_src;        // operand comes through indexing
    } op_dec_t;

    // category code followed by zeros gives the routine entry
    function automatic logic [UCODE_AW-1:0] cat_entry(opcat_e cat);
        return {cat, {ENTRY_PAD{1'b0}}};
    endfunction

endpackage

// ==== common/opcode_pkg.sv ====
// Opcode byte values of the decoded subset and the indexed postbyte.
// Any byte not listed here decodes as a bus error.
// Import inside a module body.

package opcode_pkg;

    // 8-bit alu, immediate operand
    localparam logic [7:0] SUBA_IMM = 8'h80;
    localparam logic [7:0] CMPA_IMM = 8'h81;
    localparam logic [7:0] ANDA_IMM = 8'h84;
    localparam logic [7:0] LDA_IMM  = 8'h86;
    localparam logic [7:0] EORA_IMM = 8'h88;
    localparam logic [7:0] ADDA_IMM = 8'h8b;
    localparam logic [7:0] SUBB_IMM = 8'hc0;
    localparam logic [7:0] CMPB_IMM = 8'hc1;
    localparam logic [7:0] ANDB_IMM = 8'hc4;
    localparam logic [7:0] LDB_IMM  = 8'hc6;
    localparam logic [7:0] ADDB_IMM = 8'hcb;

    // 16-bit alu, immediate operand
    localparam logic [7:0] SUBD_IMM = 8'h83;
    localparam logic [7:0] CMPX_IMM = 8'h8c;
    localparam logic [7:0] LDX_IMM  = 8'h8e;
    localparam logic [7:0] ADDD_IMM = 8'hc3;
    localparam logic [7:0] LDD_IMM  = 8'hcc;
    localparam logic [7:0] LDU_IMM  = 8'hce;

    // inherent
    localparam logic [7:0] NEGA = 8'h40;
    localparam logic [7:0] COMA = 8'h43;
    localparam logic [7:0] LSRA = 8'h44;
    localparam logic [7:0] INCA = 8'h4c;
    localparam logic [7:0] TSTA = 8'h4d;
    localparam logic [7:0] CLRA = 8'h4f;
    localparam logic [7:0] NEGB = 8'h50;
    localparam logic [7:0] CLRB = 8'h5f;
    localparam logic [7:0] DAA  = 8'h19;
    localparam logic [7:0] SEX  = 8'h1d;
    localparam logic [7:0] ABX  = 8'h3a;

    // operand through indexing
    localparam logic [7:0] SUBA_IDX = 8'ha0;
    localparam logic [7:0] CMPA_IDX = 8'ha1;
    localparam logic [7:0] LDA_IDX  = 8'ha6;
    localparam logic [7:0] ADDA_IDX = 8'hab;
    localparam logic [7:0] LDB_IDX  = 8'he6;
    localparam logic [7:0] ADDB_IDX = 8'heb;
    localparam logic [7:0] LDX_IDX  = 8'hae;
    localparam logic [7:0] LDD_IDX  = 8'hec;
    localparam logic [7:0] LDU_IDX  = 8'hee;
    localparam logic [7:0] LEAX     = 8'h30;
    localparam logic [7:0] LEAY     = 8'h31;

    // stores, always indexed
    localparam logic [7:0] STA = 8'ha7;
    localparam logic [7:0] STB = 8'he7;
    localparam logic [7:0] STD = 8'hed;
    localparam logic [7:0] STX = 8'haf;
    localparam logic [7:0] STU = 8'hef;

    // flow control and stack
    localparam logic [7:0] BRA  = 8'h20;
    localparam logic [7:0] BNE  = 8'h26;
    localparam logic [7:0] BEQ  = 8'h27;
    localparam logic [7:0] BSR  = 8'h8d;
    localparam logic [7:0] LBRA = 8'h16;
    localparam logic [7:0] LBSR = 8'h17;
    localparam logic [7:0] JMP  = 8'h6e;
    localparam logic [7:0] PSHS = 8'h34;
    localparam logic [7:0] PULS = 8'h35;
    localparam logic [7:0] PSHU = 8'h36;
    localparam logic [7:0] PULU = 8'h37;
    localparam logic [7:0] RTI  = 8'h3b;
    localparam logic [7:0] NOP  = 8'h12;

    // postbyte, bit 7 tells which view applies
    typedef struct packed {
        logic       long_fmt;   // clear here
        logic [1:0] reg_sel;
        logic [4:0] offset;     // signed 5-bit displacement
    } idx_short_t;

    typedef struct packed {
        logic       long_fmt;   // set here
        logic [1:0] reg_sel;
        logic       indirect;
        logic [3:0] mode;
    } idx_long_t;

    typedef union packed {
        idx_short_t short_v;
        idx_long_t  long_v;
    } idx_post_u;

endpackage

// ==== source/opcode_decoder.sv ====
// Stage 1 of the control unit: opcode byte to routine category.
// The category, the after-index category and the index-source flag
// are registered on each step and read by the sequencer one step later.

`timescale 1ns/1ps

module opcode_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          op,
    output ucode_pkg::op_dec_t  dec
);
    import ucode_pkg::*;
    import opcode_pkg::*;

    op_dec_t nx_dec;

    always_comb begin
        nx_dec.after_idx = dec.after_idx;   // kept until the next indexed opcode
        nx_dec.idx_src   = 1'b0;
        case (op)
            SUBA_IMM, CMPA_IMM, ANDA_IMM, LDA_IMM, EORA_IMM, ADDA_IMM,
            SUBB_IMM, CMPB_IMM, ANDB_IMM, LDB_IMM, ADDB_IMM:
                nx_dec.opcat = SINGLE_ALU;

            SUBD_IMM, CMPX_IMM, LDX_IMM, ADDD_IMM, LDD_IMM, LDU_IMM:
                nx_dec.opcat = SINGLE_ALU16;

            NEGA, COMA, LSRA, INCA, TSTA, CLRA, NEGB, CLRB, DAA, SEX, ABX:
                nx_dec.opcat = SINGLE_ALU_INH;

            // postbyte parsed first, then the real routine
            SUBA_IDX, CMPA_IDX, LDA_IDX, ADDA_IDX, LDB_IDX, ADDB_IDX: begin
                nx_dec.opcat     = PARSE_IDX;
                nx_dec.after_idx = SINGLE_ALU_IDX;
                nx_dec.idx_src   = 1'b1;
            end

            LDX_IDX, LDD_IDX, LDU_IDX, LEAX, LEAY: begin
                nx_dec.opcat     = PARSE_IDX;
                nx_dec.after_idx = SINGLE_ALU_IDX16;
                nx_dec.idx_src   = 1'b1;
            end

            STA, STB: begin
                nx_dec.opcat     = PARSE_IDX;
                nx_dec.after_idx = STORE8;
                nx_dec.idx_src   = 1'b1;
            end

            STD, STX, STU: begin
                nx_dec.opcat     = PARSE_IDX;
                nx_dec.after_idx = STORE16;
                nx_dec.idx_src   = 1'b1;
            end

            JMP: begin
                nx_dec.opcat     = PARSE_IDX;
                nx_dec.after_idx = JUMP;    // target is the effective address
                nx_dec.idx_src   = 1'b1;
            end

            BRA, BNE, BEQ, BSR:
                nx_dec.opcat = SBRANCH;

            LBRA, LBSR:
                nx_dec.opcat = LBRANCH;

            PSHS, PSHU:
                nx_dec.opcat = PSH;

            PULS, PULU:
                nx_dec.opcat = PUL;

            RTI:
                nx_dec.opcat = RTIT;

            NOP:
                nx_dec.opcat = NOPE;

            default:
                nx_dec.opcat = BUSERROR;    // halts the sequencer at ni
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.opcat     <= NOPE;
            dec.after_idx <= NOPE;
            dec.idx_src   <= 1'b0;
        end else if (cen) begin
            dec <= nx_dec;
        end
    end

endmodule

// ==== ucode/ucode_sequencer.sv ====
// Stage 2 of the control unit: microcode address sequencing.
// Picks the next store address from the sequencing bits of the
// current word, the decoded opcode, stalls, interrupts and the
// indexed postbyte. Keeps the interrupt-enable and bus-error status.

`timescale 1ns/1ps

module ucode_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic                              mem_busy,
    input  logic                              alu_busy,
    input  logic                              idx_busy,
    input  logic                              irq,
    input  logic                              firq,
    input  logic                              nmi,
    input  logic [7:0]                        op,
    input  ucode_pkg::op_dec_t                dec,
    input  ucode_pkg::ucode_ctrl_t            ctrl,
    output logic [ucode_pkg::UCODE_AW-1:0]    next_addr,
    output logic [ucode_pkg::UCODE_AW-1:0]    upc,
    output logic                              int_en,
    output logic                              buserror
);
    import ucode_pkg::*;
    import opcode_pkg::*;

    idx_post_u           post;
    logic [UCODE_AW-1:0] idx_addr;
    logic                stall;
    logic                take_ni;   // ni reached with nothing above it
    logic                int_req;

    assign post    = op;
    assign stall   = mem_busy | alu_busy | (ctrl.idx_en & idx_busy);
    assign take_ni = ~buserror & ~ctrl.idx_ret & ~ctrl.jmp_idx & ctrl.ni;
    assign int_req = nmi | firq | irq;

    // postbyte dispatch
    always_comb begin
        if (!post.short_v.long_fmt) begin
            idx_addr = IDX_SUM;     // 5-bit offset form
        end else begin
            case (post.long_v.mode)
                4'd0:                   idx_addr = IDX_RINC;
                4'd1:                   idx_addr = IDX_RINC2;
                4'd2:                   idx_addr = IDX_RDEC;
                4'd3:                   idx_addr = IDX_RDEC2;
                4'd8, 4'd12:            idx_addr = IDX_OFFSET8;
                4'd9, 4'd13:            idx_addr = IDX_OFFSET16;
                4'd15:                  idx_addr = IDX_EXTIND;
                default:                idx_addr = IDX_SUM;   // 4,5,6,11 and unused modes
            endcase
        end
    end

    always_comb begin
        if (buserror) begin
            next_addr = upc;                        // frozen until reset
        end else if (ctrl.idx_ret) begin
            next_addr = cat_entry(dec.after_idx);
        end else if (ctrl.jmp_idx) begin
            next_addr = idx_addr;
        end else if (ctrl.ni && nmi) begin
            next_addr = cat_entry(NMI_ENTRY);
        end else if (ctrl.ni && firq) begin
            next_addr = cat_entry(FIRQ_ENTRY);
        end else if (ctrl.ni && irq) begin
            next_addr = cat_entry(IRQ_ENTRY);
        end else if (ctrl.ni) begin
            // undefined opcode stays put, buserror is raised below
            next_addr = (dec.opcat == BUSERROR) ? upc : cat_entry(dec.opcat);
        end else if (stall) begin
            next_addr = upc;
        end else if (ctrl.skip_noind && !post.long_v.indirect) begin
            next_addr = upc + 2'd2;
        end else begin
            next_addr = upc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            upc      <= '0;
            int_en   <= 1'b0;
            buserror <= 1'b0;
        end else if (cen) begin
            upc <= next_addr;
            if (take_ni) begin
                int_en <= ~nmi & (firq | irq);  // nmi entry runs with it cleared
                if (!int_req && dec.opcat == BUSERROR) begin
                    buserror <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== ucode/ucode_rom.sv ====
// Stage 3 of the control unit: the 1024-word control store.
// Registers the word at next_addr on the same edge that the
// sequencer loads it into upc, so ctrl always matches upc.

`timescale 1ns/1ps

module ucode_rom (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic [ucode_pkg::UCODE_AW-1:0]    next_addr,
    output ucode_pkg::ucode_ctrl_t            ctrl
);
    import ucode_pkg::*;

    logic [UCODE_DW-1:0] mem [0:2**UCODE_AW-1];

    // sparse hex file, unlisted words stay zero
    initial begin
        for (int i = 0; i < 2**UCODE_AW; i++) begin
            mem[i] = '0;
        end
        $readmemh(UCODE_HEX, mem);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else if (cen) begin
            ctrl <= mem[next_addr];
        end
    end

endmodule

// ==== source/kcpu_ucode_top.sv ====
// Microcode control unit top level.
// Decoder, sequencer and control store in a three-stage loop.
// ctrl carries all datapath strobes as one struct.

`timescale 1ns/1ps

module kcpu_ucode_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic [7:0]                        op,
    input  logic                              mem_busy,
    input  logic                              alu_busy,
    input  logic                              idx_busy,
    input  logic                              irq,
    input  logic                              firq,
    input  logic                              nmi,
    output ucode_pkg::ucode_ctrl_t            ctrl,
    output logic [ucode_pkg::UCODE_AW-1:0]    upc,
    output logic                              int_en,
    output logic                              buserror
);
    import ucode_pkg::*;

    op_dec_t             dec;
    logic [UCODE_AW-1:0] next_addr;

    opcode_decoder u_decoder (
        .clk (clk),
        .rst (rst),
        .cen (cen),
        .op  (op),
        .dec (dec)
    );

    ucode_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .mem_busy  (mem_busy),
        .alu_busy  (alu_busy),
        .idx_busy  (idx_busy),
        .irq       (irq),
        .firq      (firq),
        .nmi       (nmi),
        .op        (op),            // read as postbyte on jmp_idx
        .dec       (dec),
        .ctrl      (ctrl),
        .next_addr (next_addr),
        .upc       (upc),
        .int_en    (int_en),
        .buserror  (buserror)
    );

    ucode_rom u_rom (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .next_addr (next_addr),
        .ctrl      (ctrl)
    );

endmodule

// ==== bench/ucode_asserts.sv ====
// Concurrent checks on the microcode sequencer.
// Bound into ucode_sequencer by the testbench; fail_count is read back there.

`timescale 1ns/1ps

module ucode_asserts (
    input logic                              clk,
    input logic                              rst,
    input logic                              cen,
    input logic                              mem_busy,
    input logic                              alu_busy,
    input logic                              idx_busy,
    input ucode_pkg::op_dec_t                dec,
    input ucode_pkg::ucode_ctrl_t            ctrl,
    input logic [ucode_pkg::UCODE_AW-1:0]    next_addr,
    input logic [ucode_pkg::UCODE_AW-1:0]    upc,
    input logic                              buserror
);
    import ucode_pkg::*;

    int unsigned fail_count = 0;
    logic        stall;
    logic        flow_ctl;      // control bits that outrank a stall

    assign stall    = mem_busy | alu_busy | (ctrl.idx_en & idx_busy);
    assign flow_ctl = ctrl.ni | ctrl.jmp_idx | ctrl.idx_ret;

    stall_holds_upc: assert property (@(posedge clk) disable iff (rst)
        cen && stall && !flow_ctl |=> $stable(upc))
        else begin
            $error("upc moved during a stall");
            fail_count++;
        end

    buserror_freezes_upc: assert property (@(posedge clk) disable iff (rst)
        buserror |=> $stable(upc))
        else begin
            $error("upc moved after a bus error");
            fail_count++;
        end

    // dispatch at ni lands on a routine entry
    ni_entry_aligned: assert property (@(posedge clk) disable iff (rst)
        cen && !buserror && ctrl.ni && !ctrl.jmp_idx && !ctrl.idx_ret
            && dec.opcat != BUSERROR |-> next_addr[3:0] == 4'd0)
        else begin
            $error("ni dispatch to an unaligned address");
            fail_count++;
        end

endmodule

// ==== bench/kcpu_ucode_tb.sv ====
// Random-stimulus testbench for the microcode control unit.
// A reference model with its own copy of the control store and its own
// opcode table predicts upc, ctrl, int_en and buserror at every step.
// Each episode runs from reset until a bus error, then checks the freeze.

`timescale 1ns/1ps

module kcpu_ucode_tb;
    import ucode_pkg::*;
    import opcode_pkg::*;

    localparam int EPISODES  = 24;
    localparam int MAX_STEPS = 4000;    // cycles allowed to reach a bus error

    logic                clk;
    logic                rst;
    logic                cen;
    logic [7:0]          op;
    logic                mem_busy;
    logic                alu_busy;
    logic                idx_busy;
    logic                irq;
    logic                firq;
    logic                nmi;
    ucode_ctrl_t         ctrl;
    logic [UCODE_AW-1:0] upc;
    logic                int_en;
    logic                buserror;

    // reference model state
    logic [UCODE_DW-1:0] rom_m [0:2**UCODE_AW-1];
    opcat_e              cat_tbl [0:255];
    opcat_e              after_tbl [0:255];
    logic                has_after [0:255];
    logic [7:0]          def_ops [$];
    logic [7:0]          grp [$];
    logic [UCODE_AW-1:0] upc_m;
    ucode_ctrl_t         ctrl_m;
    logic                int_en_m;
    logic                buserr_m;
    opcat_e              cat_m;
    opcat_e              after_m;

    kcpu_ucode_top uut (.*);

    bind ucode_sequencer ucode_asserts u_asserts (
        .clk (clk), .rst (rst), .cen (cen), .mem_busy (mem_busy),
        .alu_busy (alu_busy), .idx_busy (idx_busy), .dec (dec), .ctrl (ctrl),
        .next_addr (next_addr), .upc (upc), .buserror (buserror)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_group(input opcat_e cat, input opcat_e after, input logic indexed);
        foreach (grp[i]) begin
            cat_tbl[grp[i]]   = cat;
            after_tbl[grp[i]] = after;
            has_after[grp[i]] = indexed;
            def_ops.push_back(grp[i]);
        end
    endtask

    task automatic build_tables();
        for (int i = 0; i < 256; i++) begin
            cat_tbl[i]   = BUSERROR;    // anything unlisted
            after_tbl[i] = NOPE;
            has_after[i] = 1'b0;
        end
        grp = '{SUBA_IMM, CMPA_IMM, ANDA_IMM, LDA_IMM, EORA_IMM, ADDA_IMM,
                SUBB_IMM, CMPB_IMM, ANDB_IMM, LDB_IMM, ADDB_IMM};
        add_group(SINGLE_ALU, NOPE, 1'b0);
        grp = '{SUBD_IMM, CMPX_IMM, LDX_IMM, ADDD_IMM, LDD_IMM, LDU_IMM};
        add_group(SINGLE_ALU16, NOPE, 1'b0);
        grp = '{NEGA, COMA, LSRA, INCA, TSTA, CLRA, NEGB, CLRB, DAA, SEX, ABX};
        add_group(SINGLE_ALU_INH, NOPE, 1'b0);
        grp = '{SUBA_IDX, CMPA_IDX, LDA_IDX, ADDA_IDX, LDB_IDX, ADDB_IDX};
        add_group(PARSE_IDX, SINGLE_ALU_IDX, 1'b1);
        grp = '{LDX_IDX, LDD_IDX, LDU_IDX, LEAX, LEAY};
        add_group(PARSE_IDX, SINGLE_ALU_IDX16, 1'b1);
        grp = '{STA, STB};
        add_group(PARSE_IDX, STORE8, 1'b1);
        grp = '{STD, STX, STU};
        add_group(PARSE_IDX, STORE16, 1'b1);
        grp = '{JMP};
        add_group(PARSE_IDX, JUMP, 1'b1);
        grp = '{BRA, BNE, BEQ, BSR};
        add_group(SBRANCH, NOPE, 1'b0);
        grp = '{LBRA, LBSR};
        add_group(LBRANCH, NOPE, 1'b0);
        grp = '{PSHS, PSHU};
        add_group(PSH, NOPE, 1'b0);
        grp = '{PULS, PULU};
        add_group(PUL, NOPE, 1'b0);
        grp = '{RTI};
        add_group(RTIT, NOPE, 1'b0);
        grp = '{NOP};
        add_group(NOPE, NOPE, 1'b0);
        for (int a = 0; a < 2**UCODE_AW; a++) begin
            rom_m[a] = '0;
        end
        $readmemh("ucode/ucode.hex", rom_m);
    endtask

    // routine entry is the category code followed by four zero bits
    function automatic logic [UCODE_AW-1:0] entry_of(opcat_e cat);
        return {cat, 4'b0000};
    endfunction

    function automatic logic [UCODE_AW-1:0] idx_route(logic [7:0] pb);
        if (!pb[7])
            return IDX_SUM;
        case (pb[3:0])
            4'd0:        return IDX_RINC;
            4'd1:        return IDX_RINC2;
            4'd2:        return IDX_RDEC;
            4'd3:        return IDX_RDEC2;
            4'd8, 4'd12: return IDX_OFFSET8;
            4'd9, 4'd13: return IDX_OFFSET16;
            4'd15:       return IDX_EXTIND;
            default:     return IDX_SUM;
        endcase
    endfunction

    // one enabled step of the sequencer, in priority order
    task automatic model_step();
        logic [UCODE_AW-1:0] nxt;
        logic                stall;
        stall = mem_busy | alu_busy | (ctrl_m.idx_en & idx_busy);
        if (buserr_m)
            nxt = upc_m;
        else if (ctrl_m.idx_ret)
            nxt = entry_of(after_m);
        else if (ctrl_m.jmp_idx)
            nxt = idx_route(op);
        else if (ctrl_m.ni) begin
            if (nmi) begin
                nxt      = entry_of(NMI_ENTRY);
                int_en_m = 1'b0;            // cleared for nmi
            end else if (firq) begin
                nxt      = entry_of(FIRQ_ENTRY);
                int_en_m = 1'b1;
            end else if (irq) begin
                nxt      = entry_of(IRQ_ENTRY);
                int_en_m = 1'b1;
            end else begin
                int_en_m = 1'b0;            // plain fetch
                if (cat_m == BUSERROR) begin
                    nxt      = upc_m;
                    buserr_m = 1'b1;
                end else begin
                    nxt = entry_of(cat_m);
                end
            end
        end else if (stall)
            nxt = upc_m;
        else if (ctrl_m.skip_noind && !op[4])
            nxt = upc_m + 10'd2;
        else
            nxt = upc_m + 10'd1;
        upc_m  = nxt;
        ctrl_m = rom_m[nxt];
        cat_m  = cat_tbl[op];
        if (has_after[op])
            after_m = after_tbl[op];
    endtask

    task automatic check_ctrl(input ucode_ctrl_t exp, input ucode_ctrl_t act);
        if (act !== exp) begin
            $display("error at %0t ns: ctrl expected %h, got %h", $time, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "ctrl mismatch");
        end
    endtask

    task automatic check_upc(input logic [UCODE_AW-1:0] exp, input logic [UCODE_AW-1:0] act);
        if (act !== exp) begin
            $display("error at %0t ns: upc expected %h, got %h", $time, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "upc mismatch");
        end
    endtask

    task automatic check_status(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic check_all();
        check_upc(upc_m, upc);
        check_ctrl(ctrl_m, ctrl);
        check_status("int_en", int_en_m, int_en);
        check_status("buserror", buserr_m, buserror);
        if (uut.u_sequencer.u_asserts.fail_count != 0) begin
            $display("a bound assertion on the sequencer failed at %0t ns", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    endtask

    task automatic drive_inputs();
        cen      = ($urandom % 100) < 80;
        mem_busy = ($urandom % 100) < 20;
        alu_busy = ($urandom % 100) < 20;
        idx_busy = ($urandom % 100) < 20;
        irq      = ($urandom % 100) < 3;
        firq     = ($urandom % 100) < 2;
        nmi      = ($urandom % 100) < 2;
        if (ctrl_m.jmp_idx || ctrl_m.skip_noind)
            op = 8'($urandom);              // postbyte
        else if (($urandom % 100) < 6)
            op = 8'($urandom);              // mostly undefined
        else
            op = def_ops[$urandom % def_ops.size()];
    endtask

    task automatic run_step();
        drive_inputs();
        if (cen)
            model_step();
        @(negedge clk);
        check_all();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst      = 1'b0;
        upc_m    = '0;
        ctrl_m   = '0;
        int_en_m = 1'b0;
        buserr_m = 1'b0;
        cat_m    = NOPE;
        after_m  = NOPE;
    endtask

    initial begin
        int steps;
        void'($urandom(61));
        rst      = 1'b1;
        cen      = 1'b1;
        op       = NOP;
        mem_busy = 1'b0;
        alu_busy = 1'b0;
        idx_busy = 1'b0;
        irq      = 1'b0;
        firq     = 1'b0;
        nmi      = 1'b0;
        build_tables();
        for (int e = 0; e < EPISODES; e++) begin
            apply_reset();
            check_all();
            steps = 0;
            while (!buserror) begin
                if (steps == MAX_STEPS) begin
                    $display("no bus error within %0d cycles after reset", MAX_STEPS);
                    $display("*** TEST FAILED ***");
                    $fatal(1, "timeout");
                end
                run_step();
                steps++;
            end
            repeat (8) run_step();          // frozen until the next reset
        end
        if (uut.u_sequencer.u_asserts.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// ==== ucode/ucode.hex ====
// control store image: @address in hex, then consecutive 32-bit words in hex
// low bits: 4 ni, 3 jmp_idx, 2 idx_ret, 1 skip_noind, 0 idx_en; strobes above
@001 00000080 00000010              // reset routine, load reset vector then fetch
@010 00000400 00000210              // single alu
@020 00200400 00000210              // single alu 16
@030 00000210                       // inherent
@040 00000008                       // parse postbyte
@050 00000400 00000010              // alu on indexed operand
@060 00200400 00000010
@070 00000110                       // short branch
@080 00200000 00000110              // long branch
@090 00000110                       // jump to effective address
@0a0 00080000 00000010              // push
@0b0 00040000 00000050              // pull
@0c0 00040020 00000010              // rti
@0d0 00000010                       // nop
@0e0 00100000 00000010              // store 8
@0f0 00300000 00000010              // store 16
@200 00020000 00000810              // irq entry, stack all and mask irq
@210 00018000 00001810              // firq entry, cc and pc only
@220 00024000 00001810              // nmi entry
@280 02000003 00200400 00000004     // sum, indirect fetch skipped when direct
@290 02400001 00000004              // post increment
@2a0 02400003 00200400 00000004     // post increment by 2
@2b0 02800001 00000004              // pre decrement
@2c0 02800003 00200400 00000004     // pre decrement by 2
@2d0 02000003 00200400 00000004     // 8-bit offset
@2e0 02200003 00200400 00000004     // 16-bit offset
@2f0 00200401 00000004              // extended indirect

// ==== kcpu_ucode.f ====
common/ucode_pkg.sv
common/opcode_pkg.sv
source/opcode_decoder.sv
ucode/ucode_sequencer.sv
ucode/ucode_rom.sv
source/kcpu_ucode_top.sv
bench/ucode_asserts.sv
bench/kcpu_ucode_tb.sv
